// ==== Makefile ====
TOP       := tb_hydra
VERILATOR := verilator
FILELIST  := src.f
VFLAGS    := --binary -j 0 --top-module $(TOP)
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) design/hydra_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/buffer_arbiter.sv ====
`default_nettype none

module buffer_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  hydra_pkg::req_t req,
    output hydra_pkg::req_t grant
);

    logic [$clog2($bits(hydra_pkg::req_t))-1:0] ptr;
    logic [$clog2($bits(hydra_pkg::req_t))-1:0] win;
    logic [$clog2($bits(hydra_pkg::req_t))-1:0] idx;
    logic                                        found;

    // scan from the pointer, wrapping, first request wins
    always_comb begin
        grant = '0;
        win = ptr;
        idx = ptr;
        found = 1'b0;
        for (int k = 0; k < $bits(hydra_pkg::req_t); k++) begin
            if (!found && req[idx]) begin
                found = 1'b1;
                win = idx;
            end
            idx = idx + 1'b1;
        end
        if (found) begin
            grant[win] = 1'b1;
        end
    end

    // winner drops to lowest priority next time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= win + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/hydra.sv ====
`default_nettype none
`include "hydra_consts.svh"

module hydra (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [`HYDRA_PORTS-1:0]             wr_sop,
    input  logic [`HYDRA_PORTS-1:0]             wr_eop,
    input  logic [`HYDRA_PORTS-1:0]             wr_vld,
    input  hydra_pkg::word_t [`HYDRA_PORTS-1:0] wr_data,
    output logic [`HYDRA_PORTS-1:0]             pause,
    input  logic [`HYDRA_PORTS-1:0]             ready,
    output logic [`HYDRA_PORTS-1:0]             rd_sop,
    output logic [`HYDRA_PORTS-1:0]             rd_eop,
    output logic [`HYDRA_PORTS-1:0]             rd_vld,
    output hydra_pkg::word_t [`HYDRA_PORTS-1:0] rd_data,
    output logic                                full
);

    // ingress side
    logic [`HYDRA_PORTS-1:0]                ing_req;
    logic [`HYDRA_PORTS-1:0]                ing_grant;
    logic [`HYDRA_PORTS-1:0]                ing_new_page;
    logic [`HYDRA_PORTS-1:0]                ing_link;
    hydra_pkg::word_t [`HYDRA_PORTS-1:0]    ing_word;
    hydra_pkg::offset_t [`HYDRA_PORTS-1:0]  ing_offset;
    hydra_pkg::page_t [`HYDRA_PORTS-1:0]    ing_page;
    hydra_pkg::page_t [`HYDRA_PORTS-1:0]    ing_prev;
    logic [`HYDRA_PORTS-1:0]                desc_valid;
    logic [`HYDRA_PORTS-1:0]                desc_taken;
    hydra_pkg::port_t [`HYDRA_PORTS-1:0]    desc_port;
    hydra_pkg::prio_t [`HYDRA_PORTS-1:0]    desc_prio;
    hydra_pkg::page_t [`HYDRA_PORTS-1:0]    desc_head;
    hydra_pkg::length_t [`HYDRA_PORTS-1:0]  desc_len;

    // egress side
    logic [`HYDRA_PORTS-1:0]                egr_req;
    logic [`HYDRA_PORTS-1:0]                egr_grant;
    hydra_pkg::page_t [`HYDRA_PORTS-1:0]    egr_page;
    hydra_pkg::offset_t [`HYDRA_PORTS-1:0]  egr_offset;
    logic [`HYDRA_PORTS-1:0]                egr_free_valid;
    hydra_pkg::page_t [`HYDRA_PORTS-1:0]    egr_free_page;
    logic [`HYDRA_PORTS-1:0]                pkt_avail;
    logic [`HYDRA_PORTS-1:0]                pkt_take;
    hydra_pkg::page_t [`HYDRA_PORTS-1:0]    pkt_head;
    hydra_pkg::length_t [`HYDRA_PORTS-1:0]  pkt_len;

    // buffer access
    hydra_pkg::req_t    req;
    hydra_pkg::req_t    grant;
    logic               en;
    logic               we;
    hydra_pkg::page_t   addr_page;
    hydra_pkg::offset_t addr_offset;
    hydra_pkg::word_t   wdata;
    logic               new_page;
    logic               link;
    hydra_pkg::page_t   prev_page;
    hydra_pkg::page_t   alloc_page;
    hydra_pkg::word_t   rdata;
    hydra_pkg::page_t   rlink;
    logic               free_valid;
    hydra_pkg::page_t   free_page;

    // a write that needs a fresh page waits while the free list is empty
    assign req = {egr_req, ing_req & ~(ing_new_page & {`HYDRA_PORTS{full}})};
    assign ing_grant = grant[`HYDRA_PORTS-1:0];
    assign egr_grant = grant[2*`HYDRA_PORTS-1:`HYDRA_PORTS];
    assign en = |grant;
    assign we = |ing_grant;
    assign free_valid = |egr_free_valid;

    // grant-selected address and data
    always_comb begin
        addr_page = '0;
        addr_offset = '0;
        wdata = '0;
        new_page = 1'b0;
        link = 1'b0;
        prev_page = '0;
        free_page = '0;
        for (int i = 0; i < `HYDRA_PORTS; i++) begin
            if (ing_grant[i]) begin
                addr_page = ing_page[i];
                addr_offset = ing_offset[i];
                wdata = ing_word[i];
                new_page = ing_new_page[i];
                link = ing_link[i];
                prev_page = ing_prev[i];
            end
            if (egr_grant[i]) begin
                addr_page = egr_page[i];
                addr_offset = egr_offset[i];
            end
            if (egr_free_valid[i]) begin
                free_page = egr_free_page[i];
            end
        end
    end

    for (genvar p = 0; p < `HYDRA_PORTS; p++) begin : g_port
        port_ingress ingress_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr_sop     (wr_sop[p]),
            .wr_eop     (wr_eop[p]),
            .wr_vld     (wr_vld[p]),
            .wr_data    (wr_data[p]),
            .pause      (pause[p]),
            .req        (ing_req[p]),
            .grant      (ing_grant[p]),
            .wr_word    (ing_word[p]),
            .wr_offset  (ing_offset[p]),
            .new_page   (ing_new_page[p]),
            .wr_page    (ing_page[p]),
            .prev_page  (ing_prev[p]),
            .link       (ing_link[p]),
            .alloc_page (alloc_page),
            .desc_valid (desc_valid[p]),
            .desc_taken (desc_taken[p]),
            .desc_port  (desc_port[p]),
            .desc_prio  (desc_prio[p]),
            .desc_head  (desc_head[p]),
            .desc_len   (desc_len[p])
        );

        port_egress egress_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .ready      (ready[p]),
            .pkt_avail  (pkt_avail[p]),
            .pkt_head   (pkt_head[p]),
            .pkt_len    (pkt_len[p]),
            .pkt_take   (pkt_take[p]),
            .req        (egr_req[p]),
            .grant      (egr_grant[p]),
            .rd_page    (egr_page[p]),
            .rd_offset  (egr_offset[p]),
            .rdata      (rdata),
            .rlink      (rlink),
            .free_valid (egr_free_valid[p]),
            .free_page  (egr_free_page[p]),
            .rd_sop     (rd_sop[p]),
            .rd_eop     (rd_eop[p]),
            .rd_vld     (rd_vld[p]),
            .rd_data    (rd_data[p])
        );
    end

    buffer_arbiter arbiter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .grant (grant)
    );

    page_buffer buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .we          (we),
        .addr_page   (addr_page),
        .addr_offset (addr_offset),
        .wdata       (wdata),
        .new_page    (new_page),
        .link        (link),
        .prev_page   (prev_page),
        .alloc_page  (alloc_page),
        .rdata       (rdata),
        .rlink       (rlink),
        .free_valid  (free_valid),
        .free_page   (free_page),
        .full        (full)
    );

    queue_manager queues_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .desc_valid (desc_valid),
        .desc_taken (desc_taken),
        .desc_port  (desc_port),
        .desc_prio  (desc_prio),
        .desc_head  (desc_head),
        .desc_len   (desc_len),
        .pkt_avail  (pkt_avail),
        .pkt_head   (pkt_head),
        .pkt_len    (pkt_len),
        .pkt_take   (pkt_take)
    );

endmodule

`default_nettype wire

// ==== design/hydra_consts.svh ====
`ifndef HYDRA_CONSTS_SVH
`define HYDRA_CONSTS_SVH

// switch dimensions
`define HYDRA_PORTS 4
`define HYDRA_PRIOS 4

// shared page buffer geometry
`define HYDRA_PAGES 32
`define HYDRA_PAGE_WORDS 8

// longest packet, 8 full pages
`define HYDRA_MAX_WORDS 64

// data path width
`define HYDRA_DATA_W 16

`endif

// ==== design/hydra_pkg.sv ====
`default_nettype none
`include "hydra_consts.svh"

package hydra_pkg;

    typedef logic [`HYDRA_DATA_W-1:0] word_t;
    typedef logic [$clog2(`HYDRA_PORTS)-1:0] port_t;
    typedef logic [$clog2(`HYDRA_PRIOS)-1:0] prio_t;
    typedef logic [$clog2(`HYDRA_PAGES)-1:0] page_t;
    typedef logic [$clog2(`HYDRA_PAGE_WORDS)-1:0] offset_t;
    // one extra bit so a full 64-word count fits
    typedef logic [$clog2(`HYDRA_MAX_WORDS):0] length_t;

    // ingress requesters in the low half, egress in the high half
    typedef logic [2*`HYDRA_PORTS-1:0] req_t;

    typedef enum logic [1:0] {ING_IDLE, ING_WRITE, ING_POST} ingress_state_t;
    typedef enum logic [1:0] {EGR_IDLE, EGR_FETCH, EGR_DRAIN} egress_state_t;

endpackage

`default_nettype wire

// ==== design/page_buffer.sv ====
`default_nettype none
`include "hydra_consts.svh"

module page_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               we,
    input  hydra_pkg::page_t   addr_page,
    input  hydra_pkg::offset_t addr_offset,
    input  hydra_pkg::word_t   wdata,
    input  logic               new_page,
    input  logic               link,
    input  hydra_pkg::page_t   prev_page,
    output hydra_pkg::page_t   alloc_page,
    output hydra_pkg::word_t   rdata,
    output hydra_pkg::page_t   rlink,
    input  logic               free_valid,
    input  hydra_pkg::page_t   free_page,
    output logic               full
);

    hydra_pkg::word_t data_mem [`HYDRA_PAGES * `HYDRA_PAGE_WORDS];
    hydra_pkg::page_t link_mem [`HYDRA_PAGES];
    hydra_pkg::page_t free_mem [`HYDRA_PAGES];

    hydra_pkg::page_t                free_head;
    hydra_pkg::page_t                free_tail;
    logic [$clog2(`HYDRA_PAGES):0]   free_cnt;
    logic [$clog2(`HYDRA_PAGES):0]   free_cnt_next;
    logic                            pop;

    assign pop = en && we && new_page;
    assign alloc_page = free_mem[free_head];

    always_comb begin
        free_cnt_next = free_cnt;
        if (free_valid && !pop) begin
            free_cnt_next = free_cnt + 1'b1;
        end else if (pop && !free_valid) begin
            free_cnt_next = free_cnt - 1'b1;
        end
    end

    // circular free list, starts holding every page
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_head <= '0;
            free_tail <= '0;
            free_cnt <= `HYDRA_PAGES;
            full <= 1'b0;
            for (int i = 0; i < `HYDRA_PAGES; i++) begin
                free_mem[i] <= hydra_pkg::page_t'(i);
            end
        end else begin
            if (pop) begin
                free_head <= free_head + 1'b1;
            end
            if (free_valid) begin
                free_mem[free_tail] <= free_page;
                free_tail <= free_tail + 1'b1;
            end
            free_cnt <= free_cnt_next;
            full <= free_cnt_next == '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && we) begin
            data_mem[{addr_page, addr_offset}] <= wdata;
        end
        // chain the previous page of the packet to the one just handed out
        if (pop && link) begin
            link_mem[prev_page] <= alloc_page;
        end
        if (en && !we) begin
            rdata <= data_mem[{addr_page, addr_offset}];
            rlink <= link_mem[addr_page];
        end
    end

endmodule

`default_nettype wire

// ==== design/port_egress.sv ====
`default_nettype none

module port_egress (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ready,
    input  logic                pkt_avail,
    input  hydra_pkg::page_t    pkt_head,
    input  hydra_pkg::length_t  pkt_len,
    output logic                pkt_take,
    output logic                req,
    input  logic                grant,
    output hydra_pkg::page_t    rd_page,
    output hydra_pkg::offset_t  rd_offset,
    input  hydra_pkg::word_t    rdata,
    input  hydra_pkg::page_t    rlink,
    output logic                free_valid,
    output hydra_pkg::page_t    free_page,
    output logic                rd_sop,
    output logic                rd_eop,
    output logic                rd_vld,
    output hydra_pkg::word_t    rd_data
);

    hydra_pkg::egress_state_t state;
    hydra_pkg::length_t       len;
    hydra_pkg::length_t       cnt;
    logic                     last;

    // ready only matters while idle
    assign pkt_take = state == hydra_pkg::EGR_IDLE && ready && pkt_avail;
    assign req = state == hydra_pkg::EGR_FETCH;
    assign last = hydra_pkg::length_t'(cnt + 1'b1) == len;
    // buffer read data lands one cycle after the grant
    assign rd_data = rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= hydra_pkg::EGR_IDLE;
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
            free_valid <= 1'b0;
        end else begin
            rd_vld <= grant;
            rd_sop <= grant && cnt == '0;
            rd_eop <= grant && last;
            // page done once its last word or the packet's last word is read
            free_valid <= grant && (last || rd_offset == '1);
            case (state)
                hydra_pkg::EGR_IDLE: begin
                    if (pkt_take) begin
                        state <= hydra_pkg::EGR_FETCH;
                    end
                end
                hydra_pkg::EGR_FETCH: begin
                    if (grant) begin
                        state <= hydra_pkg::EGR_DRAIN;
                    end
                end
                hydra_pkg::EGR_DRAIN: begin
                    state <= rd_eop ? hydra_pkg::EGR_IDLE : hydra_pkg::EGR_FETCH;
                end
                default: begin
                    state <= hydra_pkg::EGR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_take) begin
            rd_page <= pkt_head;
            rd_offset <= '0;
            cnt <= '0;
            len <= pkt_len;
        end
        if (grant) begin
            rd_offset <= rd_offset + 1'b1;
            cnt <= cnt + 1'b1;
            free_page <= rd_page;
        end
        // offset wrapped, follow the link read with the last word
        if (state == hydra_pkg::EGR_DRAIN && rd_offset == '0 && !rd_eop) begin
            rd_page <= rlink;
        end
    end

endmodule

`default_nettype wire

// ==== design/port_ingress.sv ====
`default_nettype none

module port_ingress (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_sop,
    input  logic                wr_eop,
    input  logic                wr_vld,
    input  hydra_pkg::word_t    wr_data,
    output logic                pause,
    output logic                req,
    input  logic                grant,
    output hydra_pkg::word_t    wr_word,
    output hydra_pkg::offset_t  wr_offset,
    output logic                new_page,
    output hydra_pkg::page_t    wr_page,
    output hydra_pkg::page_t    prev_page,
    output logic                link,
    input  hydra_pkg::page_t    alloc_page,
    output logic                desc_valid,
    input  logic                desc_taken,
    output hydra_pkg::port_t    desc_port,
    output hydra_pkg::prio_t    desc_prio,
    output hydra_pkg::page_t    desc_head,
    output hydra_pkg::length_t  desc_len
);

    hydra_pkg::ingress_state_t state;
    logic                      held;
    logic                      held_eop;
    hydra_pkg::page_t          cur_page;
    logic                      accept;

    // one word in flight at a time, held until its buffer write is granted
    assign pause = held || state == hydra_pkg::ING_POST;
    assign accept = wr_vld && !pause;
    assign req = held;

    // offset 0 means the held word opens a page
    assign new_page = wr_offset == '0;
    assign wr_page = new_page ? alloc_page : cur_page;
    assign prev_page = cur_page;
    assign desc_valid = state == hydra_pkg::ING_POST;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= hydra_pkg::ING_IDLE;
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
            state <= hydra_pkg::ING_WRITE;
        end else if (grant) begin
            held <= 1'b0;
            if (held_eop) begin
                state <= hydra_pkg::ING_POST;
            end
        end else if (desc_taken) begin
            state <= hydra_pkg::ING_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_word <= wr_data;
            held_eop <= wr_eop;
            if (wr_sop) begin
                // header word carries destination and priority
                wr_offset <= '0;
                desc_len <= hydra_pkg::length_t'(1);
                desc_port <= hydra_pkg::port_t'(wr_data);
                desc_prio <= wr_data[$bits(hydra_pkg::port_t) +: $bits(hydra_pkg::prio_t)];
                link <= 1'b0;
            end else begin
                wr_offset <= wr_offset + 1'b1;
                desc_len <= desc_len + 1'b1;
            end
        end
        if (grant && new_page) begin
            cur_page <= alloc_page;
            link <= 1'b1;
            // first page of the packet becomes the descriptor head
            if (!link) begin
                desc_head <= alloc_page;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/queue_manager.sv ====
`default_nettype none
`include "hydra_consts.svh"

module queue_manager (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [`HYDRA_PORTS-1:0]               desc_valid,
    output logic [`HYDRA_PORTS-1:0]               desc_taken,
    input  hydra_pkg::port_t [`HYDRA_PORTS-1:0]   desc_port,
    input  hydra_pkg::prio_t [`HYDRA_PORTS-1:0]   desc_prio,
    input  hydra_pkg::page_t [`HYDRA_PORTS-1:0]   desc_head,
    input  hydra_pkg::length_t [`HYDRA_PORTS-1:0] desc_len,
    output logic [`HYDRA_PORTS-1:0]               pkt_avail,
    output hydra_pkg::page_t [`HYDRA_PORTS-1:0]   pkt_head,
    output hydra_pkg::length_t [`HYDRA_PORTS-1:0] pkt_len,
    input  logic [`HYDRA_PORTS-1:0]               pkt_take
);

    localparam int QUEUES = `HYDRA_PORTS * `HYDRA_PRIOS;
    localparam int QW = $clog2(QUEUES);
    localparam int SW = $clog2(`HYDRA_PAGES);

    hydra_pkg::page_t   head_mem [QUEUES][`HYDRA_PAGES];
    hydra_pkg::length_t len_mem [QUEUES][`HYDRA_PAGES];
    // extra pointer bit tells full from empty
    logic [SW:0]        wr_ptr [QUEUES];
    logic [SW:0]        rd_ptr [QUEUES];

    hydra_pkg::port_t   rr;
    hydra_pkg::port_t   pick;
    hydra_pkg::port_t   scan;
    logic               found;
    logic [QW-1:0]      in_q;
    logic [QW-1:0]      out_q [`HYDRA_PORTS];

    // one descriptor per cycle, round robin over ingress ports
    always_comb begin
        desc_taken = '0;
        found = 1'b0;
        pick = rr;
        scan = rr;
        for (int k = 0; k < `HYDRA_PORTS; k++) begin
            if (!found && desc_valid[scan]) begin
                found = 1'b1;
                pick = scan;
            end
            scan = scan + 1'b1;
        end
        if (found) begin
            desc_taken[pick] = 1'b1;
        end
        in_q = {desc_port[pick], desc_prio[pick]};
    end

    // strict priority, the highest non-empty level wins
    always_comb begin
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            pkt_avail[p] = 1'b0;
            out_q[p] = QW'(p * `HYDRA_PRIOS);
            for (int v = 0; v < `HYDRA_PRIOS; v++) begin
                if (wr_ptr[p * `HYDRA_PRIOS + v] != rd_ptr[p * `HYDRA_PRIOS + v]) begin
                    pkt_avail[p] = 1'b1;
                    out_q[p] = QW'(p * `HYDRA_PRIOS + v);
                end
            end
            pkt_head[p] = head_mem[out_q[p]][rd_ptr[out_q[p]][SW-1:0]];
            pkt_len[p] = len_mem[out_q[p]][rd_ptr[out_q[p]][SW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr <= '0;
            for (int q = 0; q < QUEUES; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
            end
        end else begin
            if (found) begin
                rr <= pick + 1'b1;
                wr_ptr[in_q] <= wr_ptr[in_q] + 1'b1;
            end
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                if (pkt_take[p]) begin
                    rd_ptr[out_q[p]] <= rd_ptr[out_q[p]] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            head_mem[in_q][wr_ptr[in_q][SW-1:0]] <= desc_head[pick];
            len_mem[in_q][wr_ptr[in_q][SW-1:0]] <= desc_len[pick];
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== dv/tb_hydra.sv ====
`default_nettype none
`include "hydra_consts.svh"

module tb_hydra;

    localparam int WORD_TIMEOUT = 40;
    localparam int PACKET_TIMEOUT = 20000;
    localparam int PAUSE_TIMEOUT = 2000;

    logic                                clk;
    logic                                rst_n;
    logic [`HYDRA_PORTS-1:0]             wr_sop;
    logic [`HYDRA_PORTS-1:0]             wr_eop;
    logic [`HYDRA_PORTS-1:0]             wr_vld;
    hydra_pkg::word_t [`HYDRA_PORTS-1:0] wr_data;
    logic [`HYDRA_PORTS-1:0]             pause;
    logic [`HYDRA_PORTS-1:0]             ready;
    logic [`HYDRA_PORTS-1:0]             rd_sop;
    logic [`HYDRA_PORTS-1:0]             rd_eop;
    logic [`HYDRA_PORTS-1:0]             rd_vld;
    hydra_pkg::word_t [`HYDRA_PORTS-1:0] rd_data;
    logic                                full;

    // expected packets by destination, priority and source
    hydra_pkg::word_t exp_words [64][$];
    int               exp_len [64][$];
    // packets still to be sent by each source port
    hydra_pkg::word_t tx_words [`HYDRA_PORTS][$];
    int               tx_len [`HYDRA_PORTS][$];
    int               pending [`HYDRA_PORTS];
    int               rx_prio [$];
    logic [31:0]      rand_state;
    int               errors;

    tb_clock clock_i (
        .clk (clk)
    );

    hydra hydra_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .pause   (pause),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .full    (full)
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("ERROR: %s", what);
        $display("Simulation failed");
        $fatal(1, "%s", what);
    endtask

    task automatic wait_pause_low(input int s);
        int n;
        n = 0;
        @(negedge clk);
        while (pause[s]) begin
            n++;
            if (n > PAUSE_TIMEOUT) begin
                abort_run($sformatf("pause on port %0d never dropped", s));
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_word(input int d, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!rd_vld[d]) begin
            n++;
            if (n > limit) begin
                abort_run($sformatf("port %0d never delivered the %s", d, what));
            end
            @(negedge clk);
        end
    endtask

    // header holds tag, source, priority and destination from the top bits down
    task automatic make_packet(input int s, input int dest, input int prio, input int len);
        int               idx;
        logic [31:0]      r;
        hydra_pkg::word_t w;
        idx = dest * 16 + prio * 4 + s;
        tx_len[s].push_back(len);
        exp_len[idx].push_back(len);
        pending[dest]++;
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            if (i == 0) begin
                w = {r[9:0], 2'(s), 2'(prio), 2'(dest)};
            end else begin
                w = r[15:0];
            end
            tx_words[s].push_back(w);
            exp_words[idx].push_back(w);
        end
    endtask

    // wr_vld only while pause is low
    task automatic send_word(input int s, input hydra_pkg::word_t w,
                             input logic sop, input logic eop);
        wait_pause_low(s);
        @(posedge clk);
        wr_vld[s] <= 1'b1;
        wr_sop[s] <= sop;
        wr_eop[s] <= eop;
        wr_data[s] <= w;
        @(posedge clk);
        wr_vld[s] <= 1'b0;
        wr_sop[s] <= 1'b0;
        wr_eop[s] <= 1'b0;
    endtask

    task automatic send_packet(input int s, input int skip);
        int               len;
        hydra_pkg::word_t w;
        len = tx_len[s].pop_front();
        for (int i = 0; i < len; i++) begin
            w = tx_words[s].pop_front();
            if (i >= skip) begin
                send_word(s, w, i == 0, i == len - 1);
            end
        end
    endtask

    task automatic send_head(input int s);
        send_word(s, tx_words[s][0], 1'b1, tx_len[s][0] == 1);
    endtask

    task automatic send_port(input int s);
        while (tx_len[s].size() > 0) begin
            send_packet(s, 0);
        end
    endtask

    // the header picks the expected queue that must hold this packet first
    task automatic receive_port(input int d);
        int               idx;
        int               len;
        hydra_pkg::word_t w;
        while (pending[d] > 0) begin
            wait_word(d, PACKET_TIMEOUT, "start of a packet");
            w = rd_data[d];
            check_value("rd_sop", 32'(rd_sop[d]), 32'd1);
            check_value("rd_data dest", 32'(w[1:0]), 32'(d));
            idx = int'(w[1:0]) * 16 + int'(w[3:2]) * 4 + int'(w[5:4]);
            if (exp_len[idx].size() == 0) begin
                abort_run($sformatf("port %0d sent a packet that was never queued", d));
            end
            len = exp_len[idx].pop_front();
            if (d == 0) begin
                rx_prio.push_back(int'(w[3:2]));
            end
            for (int n = 0; n < len; n++) begin
                if (n > 0) begin
                    wait_word(d, WORD_TIMEOUT, "next word of a packet");
                    check_value("rd_sop", 32'(rd_sop[d]), 32'd0);
                end
                check_value("rd_data", 32'(rd_data[d]), 32'(exp_words[idx].pop_front()));
                check_value("rd_eop", 32'(rd_eop[d]), 32'(n == len - 1));
            end
            pending[d]--;
        end
    endtask

    task automatic wait_full_low();
        int n;
        n = 0;
        @(negedge clk);
        while (full) begin
            n++;
            if (n > PAUSE_TIMEOUT) begin
                abort_run("full never fell after the buffer drained");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int dest;
        int prio;
        int len;
        rand_state = 32'd89;
        errors = 0;
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            pending[p] = 0;
        end
        rst_n <= 1'b0;
        wr_sop <= '0;
        wr_eop <= '0;
        wr_vld <= '0;
        wr_data <= '0;
        ready <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // quiet outputs after reset
        check_value("pause", 32'(pause), 32'd0);
        check_value("full", 32'(full), 32'd0);
        check_value("rd_sop", 32'(rd_sop), 32'd0);
        check_value("rd_vld", 32'(rd_vld), 32'd0);
        check_value("rd_eop", 32'(rd_eop), 32'd0);

        // random traffic from every port
        for (int s = 0; s < `HYDRA_PORTS; s++) begin
            for (int k = 0; k < 6; k++) begin
                dest = int'(next_rand() % 32'd4);
                prio = int'(next_rand() % 32'd4);
                len = int'(next_rand() % 32'd64) + 1;
                make_packet(s, dest, prio, len);
            end
        end
        @(posedge clk);
        ready <= '1;
        fork
            send_port(0);
            send_port(1);
            send_port(2);
            send_port(3);
            receive_port(0);
            receive_port(1);
            receive_port(2);
            receive_port(3);
        join

        // strict priority with packets queued while port 0 is held off
        @(posedge clk);
        ready <= '0;
        rx_prio.delete();
        for (int v = 0; v < `HYDRA_PRIOS; v++) begin
            len = int'(next_rand() % 32'd16) + 1;
            make_packet(1, 0, v, len);
        end
        send_port(1);
        wait_pause_low(1);
        @(posedge clk);
        ready[0] <= 1'b1;
        receive_port(0);
        for (int k = 0; k < `HYDRA_PRIOS; k++) begin
            check_value("rd_data prio", 32'(rx_prio[k]), 32'(3 - k));
        end

        // fill every page with nothing draining
        @(posedge clk);
        ready <= '0;
        for (int k = 0; k < `HYDRA_PAGES; k++) begin
            dest = int'(next_rand() % 32'd4);
            prio = int'(next_rand() % 32'd4);
            make_packet(2, dest, prio, `HYDRA_PAGE_WORDS);
        end
        send_port(2);
        wait_pause_low(2);
        check_value("full", 32'(full), 32'd1);
        dest = int'(next_rand() % 32'd4);
        prio = int'(next_rand() % 32'd4);
        make_packet(2, dest, prio, `HYDRA_PAGE_WORDS);
        send_head(2);
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            check_value("pause", 32'(pause[2]), 32'd1);
        end

        // drain and let the stalled packet finish
        @(posedge clk);
        ready <= '1;
        fork
            receive_port(0);
            receive_port(1);
            receive_port(2);
            receive_port(3);
            send_packet(2, 1);
        join
        wait_full_low();

        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/hydra_pkg.sv
design/buffer_arbiter.sv
design/page_buffer.sv
design/queue_manager.sv
design/port_ingress.sv
design/port_egress.sv
design/hydra.sv
dv/tb_clock.sv
dv/tb_hydra.sv
